// File: Makefile
# Verilator build of the perf counter testbench

SIM  := obj_dir/Vperf_counter_unit_tb
SRCS := $(filter-out +%,$(shell cat perf_counter_unit.f))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): perf_counter_unit.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module perf_counter_unit_tb -f perf_counter_unit.f

# Fails unless the pass line shows up in the output
run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee /dev/stderr | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir

// File: dv/perf_counter_unit_checker.sv
`default_nettype none

module perf_counter_unit_checker (
  input logic clk,
  input logic reset_i,
  input logic csr_req_i,
  input logic dbg_req_i,
  input logic csr_gnt_i,
  input logic dbg_gnt_i,
  input logic csr_rvalid_i,
  input logic dbg_rvalid_i
);
  timeunit 1ns;
  timeprecision 1ns;

  int unsigned fail_count = 0;  // Polled by the testbench

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // One response per grant, one cycle later
  csr_resp_a : assert property (@(posedge clk) disable iff (reset_i)
    csr_rvalid_i == $past(csr_gnt_i))
    else begin
      fail_count++;
      $error("core rvalid does not follow its grant by one cycle");
    end

  dbg_resp_a : assert property (@(posedge clk) disable iff (reset_i)
    dbg_rvalid_i == $past(dbg_gnt_i))
    else begin
      fail_count++;
      $error("debug rvalid does not follow its grant by one cycle");
    end

  // Debug blocks the core, and no grant without a request
  dbg_prio_a : assert property (@(posedge clk) dbg_req_i |-> !csr_gnt_i)
    else begin
      fail_count++;
      $error("core granted while debug requests");
    end

  csr_gnt_req_a : assert property (@(posedge clk) csr_gnt_i |-> csr_req_i)
    else begin
      fail_count++;
      $error("core granted without a request");
    end

  // Quiet during reset and in the first cycle out of it
  rvalid_reset_a : assert property (@(posedge clk)
    $past(reset_i) |-> !csr_rvalid_i && !dbg_rvalid_i)
    else begin
      fail_count++;
      $error("rvalid high during or right after reset");
    end

endmodule

bind perf_counter_unit perf_counter_unit_checker u_checker (
  .clk          ( clk          ),
  .reset_i      ( reset_i      ),
  .csr_req_i    ( csr_req_i    ),
  .dbg_req_i    ( dbg_req_i    ),
  .csr_gnt_i    ( csr_gnt_o    ),
  .dbg_gnt_i    ( dbg_gnt_o    ),
  .csr_rvalid_i ( csr_rvalid_o ),
  .dbg_rvalid_i ( dbg_rvalid_o )
);

`default_nettype wire

// File: dv/perf_counter_unit_tb.sv
`default_nettype none

module perf_counter_unit_tb;
  timeunit 1ns;
  timeprecision 1ns;

  import perf_pkg::*;

  localparam int        N_EXT_CNT      = 2;
  localparam int        TIMEOUT_CYCLES = 3000;    // Full run is a few hundred cycles
  localparam csr_addr_t UNMAPPED_ADDR  = 12'h7FF;

  logic                 clk = 1'b0;
  logic                 reset_i;
  logic                 instr_issue_i;
  logic                 ld_stall_i;
  logic                 jr_stall_i;
  logic                 imiss_i;
  logic                 branch_taken_i;
  logic                 data_req_i;
  logic                 data_gnt_i;
  logic                 data_we_i;
  logic [N_EXT_CNT-1:0] ext_events_i;
  logic                 csr_req_i;
  csr_addr_t            csr_addr_i;
  csr_op_t              csr_op_i;
  word_t                csr_wdata_i;
  logic                 csr_gnt_o;
  logic                 csr_rvalid_o;
  word_t                csr_rdata_o;
  logic                 dbg_req_i;
  logic                 dbg_we_i;
  csr_addr_t            dbg_addr_i;
  word_t                dbg_wdata_i;
  logic                 dbg_gnt_o;
  logic                 dbg_rvalid_o;
  word_t                dbg_rdata_o;

  int unsigned cycle_count = 0;
  int unsigned core_gnt_cycle;  // Last grant per port
  int unsigned dbg_gnt_cycle;

  perf_counter_unit #(.N_EXT_CNT(N_EXT_CNT)) DUT (.*);

  always #50 clk = ~clk;  // 100 ns period

  ////////////////////////////////////////////////////////////
  // Watchdogs
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  always @(negedge clk) begin
    if (DUT.u_checker.fail_count != 0) begin
      $display("Error at %0t ns: a handshake assertion failed", $time);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  function automatic csr_addr_t cnt_addr(input int idx);
    return csr_addr_t'(PCCR_BASE + idx);
  endfunction

  task automatic idle_events();
    {instr_issue_i, ld_stall_i, jr_stall_i, imiss_i, branch_taken_i} = '0;
    {data_req_i, data_gnt_i, data_we_i} = '0;
    ext_events_i = '0;
  endtask

  // Core request and check of the returned old value
  task automatic core_op(input csr_addr_t addr, input csr_op_t op, input word_t wdata,
                         input word_t exp_rdata);
    logic granted;
    granted = 1'b0;
    @(negedge clk);
    csr_req_i   = 1'b1;
    csr_addr_i  = addr;
    csr_op_i    = op;
    csr_wdata_i = wdata;
    while (!granted) begin
      @(posedge clk);
      granted        = csr_gnt_o;  // Comb from inputs set at the negedge
      core_gnt_cycle = cycle_count;
      @(negedge clk);
    end
    csr_req_i = 1'b0;
    csr_op_i  = CSR_OP_NONE;
    while (!csr_rvalid_o) @(negedge clk);
    check_word("csr_rdata_o", csr_rdata_o, exp_rdata);
  endtask

  task automatic dbg_op(input csr_addr_t addr, input logic we, input word_t wdata,
                        input word_t exp_rdata);
    logic granted;
    granted = 1'b0;
    @(negedge clk);
    dbg_req_i   = 1'b1;
    dbg_we_i    = we;
    dbg_addr_i  = addr;
    dbg_wdata_i = wdata;
    while (!granted) begin
      @(posedge clk);
      granted       = dbg_gnt_o;
      dbg_gnt_cycle = cycle_count;
      @(negedge clk);
    end
    dbg_req_i = 1'b0;
    dbg_we_i  = 1'b0;
    while (!dbg_rvalid_o) @(negedge clk);
    check_word("dbg_rdata_o", dbg_rdata_o, exp_rdata);
  endtask

  // Op then read back of the new value
  task automatic core_rmw(input csr_addr_t addr, input csr_op_t op, input word_t data,
                          input word_t exp_old, input word_t exp_new);
    core_op(addr, op, data, exp_old);
    core_op(addr, CSR_OP_NONE, '0, exp_new);
  endtask

  task automatic dbg_rmw(input csr_addr_t addr, input word_t data, input word_t exp_old);
    dbg_op(addr, 1'b1, data, exp_old);
    dbg_op(addr, 1'b0, '0, data);  // Write replaces the value
  endtask

  // Random pulses and data handshakes followed by a pipeline drain
  task automatic random_events(input int unsigned n, inout int unsigned n_issue,
                               inout int unsigned n_load, inout int unsigned n_ext);
    logic [31:0] rnd;
    for (int unsigned c = 0; c < n; c++) begin
      @(negedge clk);
      rnd = $urandom();
      {branch_taken_i, imiss_i, jr_stall_i, ld_stall_i, instr_issue_i} = rnd[4:0];
      {ext_events_i, data_we_i, data_gnt_i, data_req_i} = rnd[9:5];
      if (rnd[0]) n_issue++;
      if (rnd[5] && rnd[6] && !rnd[7]) n_load++;  // Granted read
      if (rnd[8]) n_ext++;
    end
    @(negedge clk);
    idle_events();
    repeat (2) @(negedge clk);
  endtask

  task automatic pulse_issue();
    @(negedge clk);
    instr_issue_i = 1'b1;
    @(negedge clk);
    instr_issue_i = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned n_issue;
    int unsigned n_load;
    int unsigned n_ext;
    int unsigned scratch [3];
    void'($urandom(14287));
    reset_i = 1'b1;
    {csr_req_i, csr_addr_i, csr_op_i, csr_wdata_i} = '0;
    {dbg_req_i, dbg_we_i, dbg_addr_i, dbg_wdata_i} = '0;
    idle_events();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Reset values
    repeat (2) begin
      @(negedge clk);
      assert (!csr_rvalid_o && !dbg_rvalid_o) else fail_run("rvalid high before any request");
    end
    core_op(PCMR_ADDR, CSR_OP_NONE, '0, 32'd1);
    core_op(PCER_ADDR, CSR_OP_NONE, '0, 32'd0);
    for (int i = 0; i < N_CORE_EVENTS + N_EXT_CNT; i++) begin
      dbg_op(cnt_addr(i), 1'b0, '0, 32'd0);
    end

    // Write, set and clear on both ports with events idle
    core_rmw(PCER_ADDR, CSR_OP_WRITE, 32'h0A6, 32'h000, 32'h0A6);
    core_rmw(PCER_ADDR, CSR_OP_SET, 32'h300, 32'h0A6, 32'h3A6);
    core_rmw(PCER_ADDR, CSR_OP_CLEAR, 32'h022, 32'h3A6, 32'h384);
    core_rmw(cnt_addr(3), CSR_OP_WRITE, 32'h1234_5678, 32'h0, 32'h1234_5678);
    core_rmw(cnt_addr(3), CSR_OP_SET, 32'h0000_8001, 32'h1234_5678, 32'h1234_D679);
    core_rmw(cnt_addr(3), CSR_OP_CLEAR, 32'h0000_0078, 32'h1234_D679, 32'h1234_D601);
    dbg_rmw(PCER_ADDR, 32'h154, 32'h384);
    dbg_rmw(cnt_addr(4), 32'hCAFE_F00D, 32'h0);
    dbg_rmw(PCER_ADDR, 32'd0, 32'h154);
    core_op(UNMAPPED_ADDR, CSR_OP_WRITE, 32'hFFFF_FFFF, 32'd0);
    core_op(UNMAPPED_ADDR, CSR_OP_NONE, '0, 32'd0);
    dbg_op(UNMAPPED_ADDR, 1'b0, '0, 32'd0);

    // Same-cycle requests where debug enables issue, load and ext 0
    fork
      core_op(PCER_ADDR, CSR_OP_NONE, '0, 32'h122);
      dbg_op(PCER_ADDR, 1'b1, 32'h122, 32'd0);
    join
    assert (dbg_gnt_cycle < core_gnt_cycle) else fail_run("core granted before debug");

    // Counting
    n_issue = 0;
    n_load  = 0;
    n_ext   = 0;
    random_events($urandom_range(60, 30), n_issue, n_load, n_ext);
    core_op(cnt_addr(1), CSR_OP_NONE, '0, n_issue);
    dbg_op(cnt_addr(5), 1'b0, '0, n_load);
    core_op(cnt_addr(8), CSR_OP_NONE, '0, n_ext);
    core_op(cnt_addr(2), CSR_OP_NONE, '0, 32'd0);  // PCER bit clear
    core_op(cnt_addr(0), CSR_OP_NONE, '0, 32'd0);

    // Global enable off freezes everything
    core_op(PCMR_ADDR, CSR_OP_CLEAR, 32'd1, 32'd1);
    random_events(20, scratch[0], scratch[1], scratch[2]);
    core_op(cnt_addr(1), CSR_OP_NONE, '0, n_issue);
    core_op(cnt_addr(5), CSR_OP_NONE, '0, n_load);
    dbg_op(cnt_addr(8), 1'b0, '0, n_ext);

    // Wrap and then saturate
    core_op(PCMR_ADDR, CSR_OP_WRITE, 32'd1, 32'd0);
    core_op(cnt_addr(1), CSR_OP_WRITE, '1, n_issue);
    pulse_issue();
    core_op(cnt_addr(1), CSR_OP_NONE, '0, 32'd0);
    core_op(PCMR_ADDR, CSR_OP_SET, 32'd2, 32'd1);
    core_op(cnt_addr(1), CSR_OP_WRITE, '1, 32'd0);
    pulse_issue();
    core_op(cnt_addr(1), CSR_OP_NONE, '0, 32'hFFFF_FFFF);

    @(negedge clk);
    if (DUT.u_checker.fail_count != 0) begin
      $display("Error at %0t ns: a handshake assertion failed", $time);
      $display("=== FAIL ===");
      $fatal(1);
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: perf_counter_unit.f
src/perf_pkg.sv
src/perf_event_sampler.sv
src/perf_counter.sv
src/perf_csr_port.sv
src/perf_counter_unit.sv
dv/perf_counter_unit_checker.sv
dv/perf_counter_unit_tb.sv

// File: src/perf_counter.sv
`default_nettype none

module perf_counter (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            event_i,     // Registered event pulse
  input  logic            count_en_i,  // PCER bit and global enable
  input  logic            saturate_i,  // Hold at all ones instead of wrapping
  input  logic            wr_en_i,     // CSR write to this counter
  input  perf_pkg::word_t wdata_i,
  output perf_pkg::word_t value_o
);

  import perf_pkg::*;

  word_t count_q;
  logic  at_max;
  logic  inc;

  assign at_max = &count_q;
  assign inc    = count_en_i & event_i;

  ////////////////////////////////////////////////////////////
  // Count register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (wr_en_i) begin
      count_q <= wdata_i;  // Write beats a same cycle event
    end else if (inc) begin
      if (!(saturate_i && at_max)) begin
        count_q <= count_q + word_t'(1);  // Rolls over to 0 in wrap mode
      end
    end
  end

  assign value_o = count_q;

endmodule

`default_nettype wire

// File: src/perf_counter_unit.sv
`default_nettype none

module perf_counter_unit #(
  parameter int N_EXT_CNT = 2
) (
  input  logic                 clk,
  input  logic                 reset_i,

  // Core events
  input  logic                 instr_issue_i,
  input  logic                 ld_stall_i,
  input  logic                 jr_stall_i,
  input  logic                 imiss_i,
  input  logic                 branch_taken_i,
  input  logic                 data_req_i,
  input  logic                 data_gnt_i,
  input  logic                 data_we_i,
  input  logic [N_EXT_CNT-1:0] ext_events_i,

  // Core CSR access
  input  logic                 csr_req_i,
  input  perf_pkg::csr_addr_t  csr_addr_i,
  input  perf_pkg::csr_op_t    csr_op_i,
  input  perf_pkg::word_t      csr_wdata_i,
  output logic                 csr_gnt_o,
  output logic                 csr_rvalid_o,
  output perf_pkg::word_t      csr_rdata_o,

  // Debug CSR access
  input  logic                 dbg_req_i,
  input  logic                 dbg_we_i,
  input  perf_pkg::csr_addr_t  dbg_addr_i,
  input  perf_pkg::word_t      dbg_wdata_i,
  output logic                 dbg_gnt_o,
  output logic                 dbg_rvalid_o,
  output perf_pkg::word_t      dbg_rdata_o
);

  import perf_pkg::*;

  localparam int N_CNT = N_CORE_EVENTS + N_EXT_CNT;

  logic [N_CNT-1:0]  event_vec;   // Registered events
  word_t [N_CNT-1:0] cnt_values;
  logic [N_CNT-1:0]  cnt_count_en;
  logic [N_CNT-1:0]  cnt_wr_en;
  word_t             cnt_wdata;   // Shared by all counters
  logic              saturate;

  ////////////////////////////////////////////////////////////
  // Event sampling
  ////////////////////////////////////////////////////////////

  perf_event_sampler #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_sampler (
    .clk            ( clk            ),
    .reset_i        ( reset_i        ),
    .instr_issue_i  ( instr_issue_i  ),
    .ld_stall_i     ( ld_stall_i     ),
    .jr_stall_i     ( jr_stall_i     ),
    .imiss_i        ( imiss_i        ),
    .branch_taken_i ( branch_taken_i ),
    .data_req_i     ( data_req_i     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_i      ( data_we_i      ),
    .ext_events_i   ( ext_events_i   ),
    .event_o        ( event_vec      )
  );

  ////////////////////////////////////////////////////////////
  // Counters, core events first then external lines
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_CNT; i++) begin : gen_counter
    perf_counter u_counter (
      .clk        ( clk             ),
      .reset_i    ( reset_i         ),
      .event_i    ( event_vec[i]    ),
      .count_en_i ( cnt_count_en[i] ),
      .saturate_i ( saturate        ),
      .wr_en_i    ( cnt_wr_en[i]    ),
      .wdata_i    ( cnt_wdata       ),
      .value_o    ( cnt_values[i]   )
    );
  end

  // CSR access and control registers
  perf_csr_port #(
    .N_EXT_CNT ( N_EXT_CNT )
  ) u_csr_port (
    .clk            ( clk          ),
    .reset_i        ( reset_i      ),
    .csr_req_i      ( csr_req_i    ),
    .csr_addr_i     ( csr_addr_i   ),
    .csr_op_i       ( csr_op_i     ),
    .csr_wdata_i    ( csr_wdata_i  ),
    .csr_gnt_o      ( csr_gnt_o    ),
    .csr_rvalid_o   ( csr_rvalid_o ),
    .csr_rdata_o    ( csr_rdata_o  ),
    .dbg_req_i      ( dbg_req_i    ),
    .dbg_we_i       ( dbg_we_i     ),
    .dbg_addr_i     ( dbg_addr_i   ),
    .dbg_wdata_i    ( dbg_wdata_i  ),
    .dbg_gnt_o      ( dbg_gnt_o    ),
    .dbg_rvalid_o   ( dbg_rvalid_o ),
    .dbg_rdata_o    ( dbg_rdata_o  ),
    .cnt_values_i   ( cnt_values   ),
    .cnt_count_en_o ( cnt_count_en ),
    .cnt_wr_en_o    ( cnt_wr_en    ),
    .cnt_wdata_o    ( cnt_wdata    ),
    .saturate_o     ( saturate     )
  );

endmodule

`default_nettype wire

// File: src/perf_csr_port.sv
`default_nettype none

module perf_csr_port #(
  parameter int N_EXT_CNT = 2
) (
  input  logic                                             clk,
  input  logic                                             reset_i,

  // Core requester
  input  logic                                             csr_req_i,
  input  perf_pkg::csr_addr_t                              csr_addr_i,
  input  perf_pkg::csr_op_t                                csr_op_i,
  input  perf_pkg::word_t                                  csr_wdata_i,
  output logic                                             csr_gnt_o,
  output logic                                             csr_rvalid_o,
  output perf_pkg::word_t                                  csr_rdata_o,

  // Debug requester, wins over the core
  input  logic                                             dbg_req_i,
  input  logic                                             dbg_we_i,
  input  perf_pkg::csr_addr_t                              dbg_addr_i,
  input  perf_pkg::word_t                                  dbg_wdata_i,
  output logic                                             dbg_gnt_o,
  output logic                                             dbg_rvalid_o,
  output perf_pkg::word_t                                  dbg_rdata_o,

  // Counter side
  input  perf_pkg::word_t [perf_pkg::N_CORE_EVENTS+N_EXT_CNT-1:0] cnt_values_i,
  output logic [perf_pkg::N_CORE_EVENTS+N_EXT_CNT-1:0]            cnt_count_en_o,
  output logic [perf_pkg::N_CORE_EVENTS+N_EXT_CNT-1:0]            cnt_wr_en_o,
  output perf_pkg::word_t                                         cnt_wdata_o,
  output logic                                                    saturate_o
);

  import perf_pkg::*;

  localparam int N_CNT = N_CORE_EVENTS + N_EXT_CNT;

  logic             acc_valid;   // Some requester is granted
  csr_addr_t        acc_addr;
  csr_op_t          acc_op;
  word_t            acc_wdata;
  logic             wr_active;   // Granted access that modifies

  logic [N_CNT-1:0] cnt_hit;     // One-hot counter select
  logic             pcer_hit;
  logic             pcmr_hit;

  word_t            old_value;   // Register value before the op
  word_t            new_value;

  logic [N_CNT-1:0] pcer_q;
  logic [1:0]       pcmr_q;
  word_t            rdata_q;
  logic             csr_rvalid_q;
  logic             dbg_rvalid_q;

  ////////////////////////////////////////////////////////////
  // Debug over core arbitration
  ////////////////////////////////////////////////////////////

  assign dbg_gnt_o = dbg_req_i;
  assign csr_gnt_o = csr_req_i & ~dbg_req_i;  // Core waits while debug asks
  assign acc_valid = dbg_req_i | csr_req_i;

  assign acc_addr  = dbg_req_i ? dbg_addr_i  : csr_addr_i;
  assign acc_wdata = dbg_req_i ? dbg_wdata_i : csr_wdata_i;
  // Debug only knows write or read
  assign acc_op    = dbg_req_i ? (dbg_we_i ? CSR_OP_WRITE : CSR_OP_NONE)
                               : csr_op_i;

  assign wr_active = acc_valid & (acc_op != CSR_OP_NONE);

  ////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////

  assign pcer_hit = (acc_addr == PCER_ADDR);
  assign pcmr_hit = (acc_addr == PCMR_ADDR);

  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_hit[i] = (acc_addr == csr_addr_t'(PCCR_BASE + i));
    end
  end

  always_comb begin
    old_value = '0;  // Unmapped reads 0
    if (pcer_hit) begin
      old_value = word_t'(pcer_q);
    end
    if (pcmr_hit) begin
      old_value = word_t'(pcmr_q);
    end
    for (int i = 0; i < N_CNT; i++) begin
      if (cnt_hit[i]) begin
        old_value = cnt_values_i[i];
      end
    end
  end

  // Write, set or clear against the old value
  always_comb begin
    case (acc_op)
      CSR_OP_WRITE: new_value = acc_wdata;
      CSR_OP_SET:   new_value = old_value | acc_wdata;
      CSR_OP_CLEAR: new_value = old_value & ~acc_wdata;
      default:      new_value = old_value;  // Read only
    endcase
  end

  ////////////////////////////////////////////////////////////
  // PCER and PCMR
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pcer_q <= PCER_RST[N_CNT-1:0];
      pcmr_q <= PCMR_RST[1:0];
    end else if (wr_active) begin
      if (pcer_hit) begin
        pcer_q <= new_value[N_CNT-1:0];  // Upper bits not stored
      end
      if (pcmr_hit) begin
        pcmr_q <= new_value[1:0];
      end
    end
  end

  // Counter controls
  assign cnt_count_en_o = pcer_q & {N_CNT{pcmr_q[PCMR_GLOBAL_EN]}};
  assign cnt_wr_en_o    = cnt_hit & {N_CNT{wr_active}};
  assign cnt_wdata_o    = new_value;
  assign saturate_o     = pcmr_q[PCMR_SATURATE];

  ////////////////////////////////////////////////////////////
  // Response, one cycle after grant
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      csr_rvalid_q <= 1'b0;
      dbg_rvalid_q <= 1'b0;
    end else begin
      csr_rvalid_q <= csr_gnt_o;
      dbg_rvalid_q <= dbg_gnt_o;
    end
  end

  // At most one grant per cycle, so one data register serves both
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      rdata_q <= old_value;
    end
  end

  assign csr_rvalid_o = csr_rvalid_q;
  assign dbg_rvalid_o = dbg_rvalid_q;
  assign csr_rdata_o  = rdata_q;
  assign dbg_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: src/perf_event_sampler.sv
`default_nettype none

module perf_event_sampler #(
  parameter int N_EXT_CNT = 2
) (
  input  logic                                          clk,
  input  logic                                          reset_i,

  // Single cycle pulses from the core
  input  logic                                          instr_issue_i,
  input  logic                                          ld_stall_i,
  input  logic                                          jr_stall_i,
  input  logic                                          imiss_i,
  input  logic                                          branch_taken_i,

  // Data memory handshake
  input  logic                                          data_req_i,
  input  logic                                          data_gnt_i,
  input  logic                                          data_we_i,

  input  logic [N_EXT_CNT-1:0]                          ext_events_i,

  output logic [perf_pkg::N_CORE_EVENTS+N_EXT_CNT-1:0] event_o  // One bit per counter
);

  import perf_pkg::*;

  localparam int N_CNT = N_CORE_EVENTS + N_EXT_CNT;

  logic             mem_load;
  logic             mem_store;
  logic [N_CNT-1:0] event_d;

  // Accepted data transfers only
  assign mem_load  = data_req_i & data_gnt_i & ~data_we_i;
  assign mem_store = data_req_i & data_gnt_i & data_we_i;

  always_comb begin
    event_d                  = '0;
    event_d[EV_CYCLES]       = 1'b1;  // Counts every cycle
    event_d[EV_INSTR_ISSUE]  = instr_issue_i;
    event_d[EV_LD_STALL]     = ld_stall_i;
    event_d[EV_JR_STALL]     = jr_stall_i;
    event_d[EV_IMISS]        = imiss_i;
    event_d[EV_MEM_LOAD]     = mem_load;
    event_d[EV_MEM_STORE]    = mem_store;
    event_d[EV_BRANCH_TAKEN] = branch_taken_i;
    // External lines sit above the core events
    event_d[N_CNT-1:N_CORE_EVENTS] = ext_events_i;
  end

  // One cycle of latency, cleared in reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      event_o <= '0;
    end else begin
      event_o <= event_d;
    end
  end

endmodule

`default_nettype wire

// File: src/perf_pkg.sv
`default_nettype none

package perf_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // CSR data word and counter value
  typedef logic [11:0] csr_addr_t;  // CSR address space
  typedef logic [1:0]  csr_op_t;    // CSR operation code

  // CSR operations, same encoding as the core's CSR ops
  localparam csr_op_t CSR_OP_NONE  = 2'd0;  // Pure read
  localparam csr_op_t CSR_OP_WRITE = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;  // OR in the data bits
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;  // Remove the data bits

  ////////////////////////////////////////////////////////////
  // Core events
  ////////////////////////////////////////////////////////////

  localparam int N_CORE_EVENTS = 8;

  localparam int EV_CYCLES       = 0;  // Always active
  localparam int EV_INSTR_ISSUE  = 1;
  localparam int EV_LD_STALL     = 2;
  localparam int EV_JR_STALL     = 3;
  localparam int EV_IMISS        = 4;
  localparam int EV_MEM_LOAD     = 5;  // Data req and gnt, we low
  localparam int EV_MEM_STORE    = 6;  // Data req and gnt, we high
  localparam int EV_BRANCH_TAKEN = 7;

  ////////////////////////////////////////////////////////////
  // CSR map and reset values
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t PCCR_BASE = 12'h780;  // Counter i at base plus i
  localparam csr_addr_t PCER_ADDR = 12'h7A0;  // Per counter enable
  localparam csr_addr_t PCMR_ADDR = 12'h7A1;  // Mode register

  localparam word_t PCER_RST = 32'h0000_0000;  // All counters off
  localparam word_t PCMR_RST = 32'h0000_0001;  // Global enable, wrap mode

  localparam int PCMR_GLOBAL_EN = 0;
  localparam int PCMR_SATURATE  = 1;

endpackage

`default_nettype wire
